// ==== video_defines.svh ====
// Geometry constants for a 640x480 display refreshed at 60 Hz
// Include this header wherever line or frame timing is needed
// The line and frame totals are built from the active size, porches and syncs
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal geometry, counted in pixel clocks
`define ACTIVE_COLS 640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48

// Vertical geometry, counted in whole lines
`define ACTIVE_ROWS 480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33

// One line is 800 clocks
`define H_TOTAL (`ACTIVE_COLS + `H_FRONT + `H_SYNC + `H_BACK)

// One frame is 525 lines
`define V_TOTAL (`ACTIVE_ROWS + `V_FRONT + `V_SYNC + `V_BACK)

`endif

// ==== video_timing_pkg.sv ====
// Types for positions on the video raster
// Import wherever column, row or raw line position counts are carried
package video_timing_pkg;

	// Column inside the active area, 0 to 639 for the default size
	typedef logic [9:0] col_t;

	// Row inside the active area, 0 to 479 for the default size
	typedef logic [9:0] row_t;

	// Position along a full line, blanking included, 0 to 799
	typedef logic [9:0] hpos_t;

	// Line number within a full frame, blanking included, 0 to 524
	typedef logic [9:0] vpos_t;

endpackage

// ==== video_pixel_pkg.sv ====
// Types for pixel data and the pattern choice
// Import wherever RGB pixels or the pattern select are handled
package video_pixel_pkg;

	// One color channel, full scale is 8'hff
	typedef logic [7:0] chan_t;

	// Packed RGB pixel with red in the top byte and blue in the bottom byte
	typedef logic [23:0] pixel_t;

	// Pattern select
	// The fourth code is not named and is painted as gray
	typedef enum logic [1:0] {
		PAT_BARS    = 2'd0,
		PAT_CHECKER = 2'd1,
		PAT_GRAY    = 2'd2
	} pattern_t;

endpackage

// ==== video_sync_gen.sv ====
// Free-running raster timing for a 640x480 display
// Drives active-low syncs and active-high blanks, all registered
// Reset restarts the raster at the first active pixel of line 0
`timescale 1ns/1ps
`include "video_defines.svh"

module video_sync_gen (
	input  logic i_Clk,
	input  logic i_rst,
	output logic o_hsync,
	output logic o_vsync,
	output logic o_hblank,
	output logic o_vblank
);
	import video_timing_pkg::*;

	// Counter ranges derived from the geometry header
	localparam hpos_t H_LAST       = hpos_t'(`H_TOTAL - 1);
	localparam hpos_t H_BLANK_FROM = hpos_t'(`ACTIVE_COLS);
	localparam hpos_t H_SYNC_FROM  = hpos_t'(`ACTIVE_COLS + `H_FRONT);
	localparam hpos_t H_SYNC_TO    = hpos_t'(`ACTIVE_COLS + `H_FRONT + `H_SYNC);
	localparam vpos_t V_LAST       = vpos_t'(`V_TOTAL - 1);
	localparam vpos_t V_BLANK_FROM = vpos_t'(`ACTIVE_ROWS);
	localparam vpos_t V_SYNC_FROM  = vpos_t'(`ACTIVE_ROWS + `V_FRONT);
	localparam vpos_t V_SYNC_TO    = vpos_t'(`ACTIVE_ROWS + `V_FRONT + `V_SYNC);

	hpos_t r_hpos;
	vpos_t r_vpos;
	logic  w_line_end;

	// Last clock of the line, where the vertical count steps
	assign w_line_end = (r_hpos == H_LAST);

	// Position counters wrap at the line and frame totals
	always_ff @(posedge i_Clk) begin
		if (i_rst) begin
			r_hpos <= '0;
			r_vpos <= '0;
		end else if (w_line_end) begin
			r_hpos <= '0;
			if (r_vpos == V_LAST) begin
				r_vpos <= '0;
			end else begin
				r_vpos <= r_vpos + 1'b1;
			end
		end else begin
			r_hpos <= r_hpos + 1'b1;
		end
	end

	// Decode the counter ranges into levels, one cycle behind the counters
	// Both blanks come out of reset high
	// The first cycle after reset then shows a falling vblank, so a frame start is seen at once
	always_ff @(posedge i_Clk) begin
		if (i_rst) begin
			o_hsync  <= 1'b1;
			o_vsync  <= 1'b1;
			o_hblank <= 1'b1;
			o_vblank <= 1'b1;
		end else begin
			o_hblank <= (r_hpos >= H_BLANK_FROM);
			o_vblank <= (r_vpos >= V_BLANK_FROM);
			// Sync is low inside its window and high elsewhere
			o_hsync  <= !((r_hpos >= H_SYNC_FROM) && (r_hpos < H_SYNC_TO));
			o_vsync  <= !((r_vpos >= V_SYNC_FROM) && (r_vpos < V_SYNC_TO));
		end
	end

	// A sync pulse must sit inside the blanking interval of the same direction
	a_hsync_in_hblank: assert property (
		@(posedge i_Clk) disable iff (i_rst)
		!o_hsync |-> o_hblank
	) else $error("hsync low outside hblank");

	a_vsync_in_vblank: assert property (
		@(posedge i_Clk) disable iff (i_rst)
		!o_vsync |-> o_vblank
	) else $error("vsync low outside vblank");

endmodule

// ==== blanking_to_count.sv ====
// Rebuilds active-area column and row counts from horizontal and vertical blanks
// Syncs, active level and counts leave together one cycle after the inputs
// Lock rises on the first frame start and holds until reset
`timescale 1ns/1ps

module blanking_to_count #(
	parameter int ACTIVE_COLS = 640,
	parameter int ACTIVE_ROWS = 480
) (
	input  logic                   i_Clk,
	input  logic                   i_rst,
	input  logic                   i_hsync,
	input  logic                   i_vsync,
	input  logic                   i_hblank,
	input  logic                   i_vblank,
	output logic                   o_locked,
	output logic                   o_hsync,
	output logic                   o_vsync,
	output logic                   o_active,
	output video_timing_pkg::col_t o_col,
	output video_timing_pkg::row_t o_row
);
	import video_timing_pkg::*;

	localparam col_t COL_LAST = col_t'(ACTIVE_COLS - 1);
	localparam row_t ROW_LAST = row_t'(ACTIVE_ROWS - 1);

	logic r_hblank;
	logic r_vblank;
	logic w_frame_start;
	logic w_line_start;
	logic w_active_in;
	col_t r_col;
	row_t r_row;
	col_t w_cur_col;
	row_t w_cur_row;

	// Falling blank edges, found against the copies from the previous cycle
	assign w_frame_start = r_vblank & ~i_vblank;
	assign w_line_start  = r_hblank & ~i_hblank;
	assign w_active_in   = ~i_hblank & ~i_vblank;

	// Position of the pixel now at the input
	// An edge forces zero in the same cycle, so no half-cycle offset is needed
	assign w_cur_col = (w_frame_start || w_line_start) ? '0 : r_col;
	assign w_cur_row = w_frame_start ? '0 : r_row;

	// Blank history and the sticky lock flag
	always_ff @(posedge i_Clk) begin
		if (i_rst) begin
			r_hblank <= 1'b1;
			r_vblank <= 1'b1;
			o_locked <= 1'b0;
		end else begin
			r_hblank <= i_hblank;
			r_vblank <= i_vblank;
			if (w_frame_start) begin
				o_locked <= 1'b1;
			end
		end
	end

	// The counters hold the position of the next active pixel
	// They advance only on active input cycles
	always_ff @(posedge i_Clk) begin
		if (i_rst) begin
			r_col <= '0;
			r_row <= '0;
		end else if (w_active_in) begin
			if (w_cur_col == COL_LAST) begin
				r_col <= '0;
				r_row <= (w_cur_row == ROW_LAST) ? '0 : w_cur_row + 1'b1;
			end else begin
				r_col <= w_cur_col + 1'b1;
				r_row <= w_cur_row;
			end
		end else begin
			// Keep any zeroing from an edge that lands while still blanked
			r_col <= w_cur_col;
			r_row <= w_cur_row;
		end
	end

	// Output stage aligns syncs and counts; counts read zero while blanked
	always_ff @(posedge i_Clk) begin
		if (i_rst) begin
			o_hsync  <= 1'b1;
			o_vsync  <= 1'b1;
			o_active <= 1'b0;
			o_col    <= '0;
			o_row    <= '0;
		end else begin
			o_hsync  <= i_hsync;
			o_vsync  <= i_vsync;
			o_active <= w_active_in;
			o_col    <= w_active_in ? w_cur_col : '0;
			o_row    <= w_active_in ? w_cur_row : '0;
		end
	end

	// The column must not run past the active width while pixels are shown
	a_col_in_range: assert property (
		@(posedge i_Clk) disable iff (i_rst)
		o_active |-> (o_col < ACTIVE_COLS)
	) else $error("column %0d out of range", o_col);

	// Lock drops only as a result of reset
	a_lock_sticky: assert property (
		@(posedge i_Clk)
		$fell(o_locked) |-> $past(i_rst)
	) else $error("lock fell without reset");

endmodule

// ==== test_pattern_gen.sv ====
// Paints color bars, a checkerboard or a flat gray field from column and row
// The pixel is registered with the syncs and active level, so all leave aligned
// Pixels outside the active area are zero
`timescale 1ns/1ps

module test_pattern_gen (
	input  logic                     i_Clk,
	input  logic                     i_rst,
	input  video_pixel_pkg::pattern_t i_pattern,
	input  logic                     i_hsync,
	input  logic                     i_vsync,
	input  logic                     i_active,
	input  video_timing_pkg::col_t   i_col,
	input  video_timing_pkg::row_t   i_row,
	output logic                     o_hsync,
	output logic                     o_vsync,
	output logic                     o_de,
	output video_pixel_pkg::pixel_t  o_pixel
);
	import video_timing_pkg::*;
	import video_pixel_pkg::*;

	// Eight bars across 640 columns
	localparam col_t  BAR_WIDTH = col_t'(80);
	localparam chan_t CH_GRAY   = 8'h80;

	logic [2:0] w_bar_idx;
	pixel_t     w_color;

	// Bar colors in order white, yellow, cyan, green, magenta, red, blue, black
	function automatic pixel_t bar_color(input logic [2:0] idx);
		logic [2:0] rgb;
		case (idx)
			3'd0:    rgb = 3'b111;
			3'd1:    rgb = 3'b110;
			3'd2:    rgb = 3'b011;
			3'd3:    rgb = 3'b010;
			3'd4:    rgb = 3'b101;
			3'd5:    rgb = 3'b100;
			3'd6:    rgb = 3'b001;
			default: rgb = 3'b000;
		endcase
		// Each channel is either fully on or fully off
		return {{8{rgb[2]}}, {8{rgb[1]}}, {8{rgb[0]}}};
	endfunction

	assign w_bar_idx = 3'(i_col / BAR_WIDTH);

	// Color for the current position under the selected pattern
	always_comb begin
		case (i_pattern)
			PAT_BARS:    w_color = bar_color(w_bar_idx);
			// Squares 32 pixels on a side
			PAT_CHECKER: w_color = (i_col[5] ^ i_row[5]) ? 24'hffffff : 24'h000000;
			// PAT_GRAY and the unnamed fourth code both land here
			default:     w_color = {3{CH_GRAY}};
		endcase
	end

	// One more register stage keeps the pixel level with its syncs
	always_ff @(posedge i_Clk) begin
		if (i_rst) begin
			o_hsync <= 1'b1;
			o_vsync <= 1'b1;
			o_de    <= 1'b0;
			o_pixel <= '0;
		end else begin
			o_hsync <= i_hsync;
			o_vsync <= i_vsync;
			o_de    <= i_active;
			o_pixel <= i_active ? w_color : '0;
		end
	end

	// The display must see black whenever data enable is low
	a_blank_pixel_zero: assert property (
		@(posedge i_Clk) disable iff (i_rst)
		!o_de |-> (o_pixel == '0)
	) else $error("pixel %h while de low", o_pixel);

endmodule

// ==== video_pattern_top.sv ====
// Test-pattern source for a 640x480 display at 60 Hz
// Chains the raster timing, the blank-to-count stage and the painter
// Outputs are two cycles behind the raster and mutually aligned
`timescale 1ns/1ps
`include "video_defines.svh"

module video_pattern_top (
	input  logic                      i_Clk,
	input  logic                      i_rst,
	input  video_pixel_pkg::pattern_t i_pattern,
	output logic                      o_hsync,
	output logic                      o_vsync,
	output logic                      o_de,
	output video_pixel_pkg::pixel_t   o_pixel,
	output logic                      o_locked
);
	import video_timing_pkg::*;

	// Raster timing levels
	logic w_hsync;
	logic w_vsync;
	logic w_hblank;
	logic w_vblank;

	// Counted positions, one cycle behind the raster
	logic w_hsync_d;
	logic w_vsync_d;
	logic w_active;
	col_t w_col;
	row_t w_row;

	video_sync_gen u_video_sync_gen (
		.i_Clk    (i_Clk),
		.i_rst    (i_rst),
		.o_hsync  (w_hsync),
		.o_vsync  (w_vsync),
		.o_hblank (w_hblank),
		.o_vblank (w_vblank)
	);

	blanking_to_count #(
		.ACTIVE_COLS (`ACTIVE_COLS),
		.ACTIVE_ROWS (`ACTIVE_ROWS)
	) u_blanking_to_count (
		.i_Clk    (i_Clk),
		.i_rst    (i_rst),
		.i_hsync  (w_hsync),
		.i_vsync  (w_vsync),
		.i_hblank (w_hblank),
		.i_vblank (w_vblank),
		.o_locked (o_locked),
		.o_hsync  (w_hsync_d),
		.o_vsync  (w_vsync_d),
		.o_active (w_active),
		.o_col    (w_col),
		.o_row    (w_row)
	);

	test_pattern_gen u_test_pattern_gen (
		.i_Clk     (i_Clk),
		.i_rst     (i_rst),
		.i_pattern (i_pattern),
		.i_hsync   (w_hsync_d),
		.i_vsync   (w_vsync_d),
		.i_active  (w_active),
		.i_col     (w_col),
		.i_row     (w_row),
		.o_hsync   (o_hsync),
		.o_vsync   (o_vsync),
		.o_de      (o_de),
		.o_pixel   (o_pixel)
	);

endmodule

// ==== tb_video_pattern.sv ====
// Directed testbench for the 640x480 test-pattern source
// A model rebuilds row and column from the DUT syncs and checks every pixel
// Covers reset state, lock, sync geometry, all three patterns and a mid-frame reset
`timescale 1ns/1ps
`include "video_defines.svh"

module tb_video_pattern;
	import video_pixel_pkg::*;

	localparam int LINE = `H_TOTAL;
	localparam int FRAME = `H_TOTAL * `V_TOTAL;
	// Four frames cover every test with room to spare
	localparam int LIMIT = 4 * FRAME + 2000;
	localparam logic [31:0] SEED = 32'hfca7403d;

	logic     i_Clk;
	logic     i_rst;
	pattern_t i_pattern;
	logic     o_hsync;
	logic     o_vsync;
	logic     o_de;
	pixel_t   o_pixel;
	logic     o_locked;

	int errors = 0;
	int cycles = 0;
	int n_vs = 0;
	logic [31:0] lfsr = SEED;

	// Model state rebuilt from the DUT outputs
	int row;
	int col;
	int t_hs_fall;
	int t_de_rise;
	int t_de_fall;
	int t_vs_fall;
	logic prev_hs;
	logic prev_vs;
	logic prev_de;
	logic was_locked;

	video_pattern_top u_video_pattern_top (
		.i_Clk     (i_Clk),
		.i_rst     (i_rst),
		.i_pattern (i_pattern),
		.o_hsync   (o_hsync),
		.o_vsync   (o_vsync),
		.o_de      (o_de),
		.o_pixel   (o_pixel),
		.o_locked  (o_locked)
	);

	initial begin
		i_Clk = 1'b0;
		forever #5 i_Clk = ~i_Clk;
	end

	// Cycle counter doubles as the time base of the model
	always @(posedge i_Clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run went past %0d cycles without finishing", LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("Error %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// White, yellow, cyan, green, magenta, red, blue and black from left to right
	function automatic pixel_t bar_rgb(input int idx);
		case (idx)
			0:       return 24'hffffff;
			1:       return 24'hffff00;
			2:       return 24'h00ffff;
			3:       return 24'h00ff00;
			4:       return 24'hff00ff;
			5:       return 24'hff0000;
			6:       return 24'h0000ff;
			default: return 24'h000000;
		endcase
	endfunction

	// Bars are 80 columns wide and checker squares are 32 pixels on a side
	function automatic pixel_t model_pixel(input pattern_t p, input int c, input int r);
		if (p == PAT_BARS) return bar_rgb(c / 80);
		if (p == PAT_CHECKER) return (((c ^ r) >> 5) & 1) ? 24'hffffff : 24'h000000;
		return 24'h808080;
	endfunction

	task automatic clear_model();
		row = -1;
		col = 0;
		t_hs_fall = -1;
		t_de_fall = -1;
		prev_hs = 1'b1;
		prev_vs = 1'b1;
		prev_de = 1'b0;
		was_locked = 1'b0;
	endtask

	// Each clock samples at the falling edge, checks, then drives the next pattern
	// The pixel in view was painted with the pattern still on i_pattern
	task automatic tick(input pattern_t next_pat);
		pixel_t exp_pix;
		@(negedge i_Clk);
		if (i_rst) begin
			check_bit("o_hsync", o_hsync, 1'b1);
			check_bit("o_vsync", o_vsync, 1'b1);
			check_bit("o_de", o_de, 1'b0);
			check_bit("o_locked", o_locked, 1'b0);
			check_pixel("o_pixel", o_pixel, '0);
			clear_model();
		end else begin
			if (!o_hsync && prev_hs) begin
				if (t_hs_fall >= 0) check_count("hsync period", cycles - t_hs_fall, LINE);
				if (t_de_fall >= 0) check_count("front porch", cycles - t_de_fall, `H_FRONT);
				t_hs_fall = cycles;
				t_de_fall = -1;
			end
			if (o_hsync && !prev_hs) check_count("hsync low", cycles - t_hs_fall, `H_SYNC);
			if (o_de && !prev_de) begin
				t_de_rise = cycles;
				row++;
				col = 0;
			end
			if (!o_de && prev_de) begin
				check_count("de high", cycles - t_de_rise, `ACTIVE_COLS);
				t_de_fall = cycles;
			end
			// Vsync falls after the last active line of the frame
			if (!o_vsync && prev_vs) begin
				check_count("lines per frame", row + 1, `ACTIVE_ROWS);
				t_vs_fall = cycles;
				row = -1;
			end
			if (o_vsync && !prev_vs) begin
				check_count("vsync low", cycles - t_vs_fall, `V_SYNC * LINE);
				n_vs++;
			end
			exp_pix = o_de ? model_pixel(i_pattern, col, row) : '0;
			check_pixel("o_pixel", o_pixel, exp_pix);
			// Lock must be up by the first active pixel and then hold
			if (o_de || was_locked) check_bit("o_locked", o_locked, 1'b1);
			was_locked = was_locked | o_locked;
			col++;
			prev_hs = o_hsync;
			prev_vs = o_vsync;
			prev_de = o_de;
		end
		i_pattern = next_pat;
	endtask

	task automatic apply_reset();
		i_rst = 1'b1;
		repeat (2) tick(i_pattern);
		i_rst = 1'b0;
	endtask

	task automatic test_reset_state();
		apply_reset();
		tick(PAT_BARS);
		check_bit("o_hsync", o_hsync, 1'b1);
		check_bit("o_vsync", o_vsync, 1'b1);
		check_bit("o_de", o_de, 1'b0);
		check_bit("o_locked", o_locked, 1'b0);
	endtask

	// The first frame after reset carries lock, geometry and color bars
	task automatic test_bars_lock_geometry();
		repeat (FRAME) tick(PAT_BARS);
		check_count("vsync pulses", n_vs, 1);
		check_bit("o_locked", o_locked, 1'b1);
	endtask

	task automatic test_checker_gray_random();
		logic [31:0] gap;
		logic [31:0] v;
		pattern_t    pat;
		repeat (FRAME) tick(PAT_CHECKER);
		repeat (FRAME) tick(PAT_GRAY);
		pat = PAT_GRAY;
		// About one change in 64 clocks lands anywhere in the line
		for (int k = 0; k < 200 * LINE + 300; k++) begin
			draw_bits(6, gap);
			if (gap[5:0] == 6'd0) begin
				draw_bits(2, v);
				pat = (v[1:0] == 2'd3) ? PAT_GRAY : pattern_t'(v[1:0]);
			end
			tick(pat);
		end
	endtask

	// Called in the middle of an active line
	task automatic test_mid_frame_reset();
		check_bit("o_de", o_de, 1'b1);
		apply_reset();
		repeat (200 * LINE) tick(PAT_BARS);
		check_bit("o_locked", o_locked, 1'b1);
	endtask

	initial begin
		i_rst = 1'b1;
		i_pattern = PAT_BARS;
		clear_model();
		test_reset_state();
		test_bars_lock_geometry();
		test_checker_gray_random();
		test_mid_frame_reset();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+.
video_timing_pkg.sv
video_pixel_pkg.sv
video_sync_gen.sv
blanking_to_count.sv
test_pattern_gen.sv
video_pattern_top.sv
tb_video_pattern.sv
